/* compile.f */
+incdir+hdl
hdl/glbl_cfg_pkg.sv
hdl/byte_en_reg.sv
hdl/reg_bus_front.sv
hdl/riscv_cfg_bank.sv
hdl/sdram_cfg_bank.sv
hdl/id_reg_bank.sv
hdl/glbl_cfg_top.sv
dv/glbl_cfg_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; status follows the testbench verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module glbl_cfg_tb -o glbl_cfg_sim \
    && ./obj_dir/glbl_cfg_sim | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

/* dv/glbl_cfg_tb.sv */
`timescale 1ns/1ps

`include "glbl_cfg_params.svh"

module glbl_cfg_tb;

    localparam int RESET_CYCLES      = 5;
    localparam int CYCLES_PER_ACCESS = 8;
    localparam int CLK_PERIOD        = 10;
    // Edges from reg_cs rising to reg_ack rising
    localparam int ACK_LATENCY       = 2;

    // DUT ports
    logic                        mclk;
    logic                        reset_n;
    logic                        reg_cs;
    logic                        reg_wr;
    glbl_cfg_pkg::reg_addr_t     reg_addr;
    glbl_cfg_pkg::reg_word_t     reg_wdata;
    glbl_cfg_pkg::byte_en_t      reg_be;
    glbl_cfg_pkg::reg_word_t     reg_rdata;
    logic                        reg_ack;
    glbl_cfg_pkg::reg_word_t     fuse_mhartid;
    glbl_cfg_pkg::irq_cfg_t      irq_cfg;
    logic                        sdr_init_done;
    glbl_cfg_pkg::sdr_cfg_t      sdr_cfg;

    // Stimulus table, one queue per column
    string                       tc_name  [$];
    bit                          tc_wr    [$];
    glbl_cfg_pkg::reg_addr_t     tc_addr  [$];
    glbl_cfg_pkg::reg_word_t     tc_wdata [$];
    glbl_cfg_pkg::byte_en_t      tc_be    [$];
    bit                          tc_init  [$];
    glbl_cfg_pkg::reg_word_t     tc_exp   [$];

    // Register image, indexed by word
    glbl_cfg_pkg::reg_word_t     img [16];

    bit table_ready = 1'b0;

    glbl_cfg_top DUT (
        .mclk          (mclk),
        .reset_n       (reset_n),
        .reg_cs        (reg_cs),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_be        (reg_be),
        .reg_rdata     (reg_rdata),
        .reg_ack       (reg_ack),
        .fuse_mhartid  (fuse_mhartid),
        .irq_cfg       (irq_cfg),
        .sdr_init_done (sdr_init_done),
        .sdr_cfg       (sdr_cfg)
    );

    // 10 ns clock
    initial mclk = 1'b0;
    always #5 mclk = ~mclk;

    // ------------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------------
    task automatic add_entry(string name, bit wr, glbl_cfg_pkg::reg_addr_t addr,
                             glbl_cfg_pkg::reg_word_t wdata, glbl_cfg_pkg::byte_en_t be,
                             bit init, glbl_cfg_pkg::reg_word_t exp_word);
        tc_name.push_back(name);
        tc_wr.push_back(wr);
        tc_addr.push_back(addr);
        tc_wdata.push_back(wdata);
        tc_be.push_back(be);
        tc_init.push_back(init);
        tc_exp.push_back(exp_word);
    endtask

    task automatic build_table();
        // Reset values, init-done at both levels on word 4
        add_entry("rst_scratch0", 1'b0, 8'h00, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_SCRATCH);
        add_entry("rst_hartid", 1'b0, 8'h04, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_HARTID);
        add_entry("rst_scratch2", 1'b0, 8'h08, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_SCRATCH);
        add_entry("rst_irq", 1'b0, 8'h0C, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_IRQ);
        add_entry("rst_sdr1_init0", 1'b0, 8'h10, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_SDR1);
        add_entry("rst_sdr1_init1", 1'b0, 8'h10, 32'h0, 4'hF, 1'b1,
                  `GLBL_CFG_RST_SDR1 | 32'h4000_0000);
        add_entry("rst_sdr2", 1'b0, 8'h14, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_SDR2);
        add_entry("rst_chip_tag", 1'b0, 8'h18, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_CHIP_TAG);
        add_entry("rst_rel_date", 1'b0, 8'h1C, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_REL_DATE);
        add_entry("rst_revision", 1'b0, 8'h20, 32'h0, 4'hF, 1'b0, `GLBL_CFG_RST_REVISION);
        // Full word writes and read back
        add_entry("wr_scratch0", 1'b1, 8'h00, 32'h1234_5678, 4'hF, 1'b0, 32'h0);
        add_entry("rd_scratch0", 1'b0, 8'h00, 32'h0, 4'hF, 1'b0, 32'h1234_5678);
        add_entry("wr_hartid", 1'b1, 8'h04, 32'h0000_0003, 4'hF, 1'b0, 32'h0);
        add_entry("rd_hartid", 1'b0, 8'h04, 32'h0, 4'hF, 1'b0, 32'h0000_0003);
        add_entry("wr_scratch2", 1'b1, 8'h08, 32'hDEAD_BEEF, 4'hF, 1'b0, 32'h0);
        add_entry("rd_scratch2", 1'b0, 8'h08, 32'h0, 4'hF, 1'b0, 32'hDEAD_BEEF);
        add_entry("wr_sdr2", 1'b1, 8'h14, 32'hF234_5678, 4'hF, 1'b0, 32'h0);
        add_entry("rd_sdr2", 1'b0, 8'h14, 32'h0, 4'hF, 1'b0, 32'hF234_5678);
        add_entry("wr_chip_tag", 1'b1, 8'h18, 32'hCAFE_F00D, 4'hF, 1'b0, 32'h0);
        add_entry("rd_chip_tag", 1'b0, 8'h18, 32'h0, 4'hF, 1'b0, 32'hCAFE_F00D);
        add_entry("wr_rel_date", 1'b1, 8'h1C, 32'h0102_0304, 4'hF, 1'b0, 32'h0);
        add_entry("rd_rel_date", 1'b0, 8'h1C, 32'h0, 4'hF, 1'b0, 32'h0102_0304);
        add_entry("wr_revision", 1'b1, 8'h20, 32'h0002_0001, 4'hF, 1'b0, 32'h0);
        add_entry("rd_revision", 1'b0, 8'h20, 32'h0, 4'hF, 1'b0, 32'h0002_0001);
        // Lane merge on word 0
        add_entry("be_scratch0_lo", 1'b1, 8'h00, 32'h9988_7766, 4'h5, 1'b0, 32'h0);
        add_entry("rd_scratch0_lo", 1'b0, 8'h00, 32'h0, 4'hF, 1'b0, 32'h1288_5666);
        add_entry("be_scratch0_hi", 1'b1, 8'h00, 32'hA1B2_C3D4, 4'hA, 1'b0, 32'h0);
        add_entry("rd_scratch0_hi", 1'b0, 8'h00, 32'h0, 4'hF, 1'b0, 32'hA188_C366);
        // Interrupt control, bits 31..20 never stored
        add_entry("wr_irq_ones", 1'b1, 8'h0C, 32'hFFFF_FFFF, 4'hF, 1'b0, 32'h0);
        add_entry("rd_irq_ones", 1'b0, 8'h0C, 32'h0, 4'hF, 1'b0, 32'h000F_FFFF);
        add_entry("be_irq_lane2", 1'b1, 8'h0C, 32'h00A5_0000, 4'h4, 1'b0, 32'h0);
        add_entry("rd_irq_lane2", 1'b0, 8'h0C, 32'h0, 4'hF, 1'b0, 32'h0005_FFFF);
        // SDRAM control 1, status bits 31 and 30
        add_entry("wr_sdr1_ones", 1'b1, 8'h10, 32'hFFFF_FFFF, 4'hF, 1'b0, 32'h0);
        add_entry("rd_sdr1_ones_i0", 1'b0, 8'h10, 32'h0, 4'hF, 1'b0, 32'h3FFF_FFFF);
        add_entry("rd_sdr1_ones_i1", 1'b0, 8'h10, 32'h0, 4'hF, 1'b1, 32'h7FFF_FFFF);
        add_entry("be_sdr1_mid", 1'b1, 8'h10, 32'h0012_3400, 4'h6, 1'b1, 32'h0);
        add_entry("rd_sdr1_mid", 1'b0, 8'h10, 32'h0, 4'hF, 1'b0, 32'h3F12_34FF);
        add_entry("be_sdr1_top", 1'b1, 8'h10, 32'hC000_0000, 4'h8, 1'b0, 32'h0);
        add_entry("rd_sdr1_top_i1", 1'b0, 8'h10, 32'h0, 4'hF, 1'b1, 32'h4012_34FF);
        add_entry("rd_sdr1_top_i0", 1'b0, 8'h10, 32'h0, 4'hF, 1'b0, 32'h0012_34FF);
        // Unused words 9 to 15
        add_entry("rd_idx9", 1'b0, 8'h24, 32'h0, 4'hF, 1'b0, 32'h0);
        add_entry("wr_idx9", 1'b1, 8'h24, 32'hFFFF_FFFF, 4'hF, 1'b0, 32'h0);
        add_entry("rd_idx9_after", 1'b0, 8'h24, 32'h0, 4'hF, 1'b0, 32'h0);
        add_entry("wr_idx15", 1'b1, 8'h3C, 32'h1111_1111, 4'hF, 1'b0, 32'h0);
        add_entry("rd_idx15", 1'b0, 8'h3C, 32'h0, 4'hF, 1'b0, 32'h0);
        add_entry("rd_scratch0_kept", 1'b0, 8'h00, 32'h0, 4'hF, 1'b0, 32'hA188_C366);
        add_entry("rd_revision_kept", 1'b0, 8'h20, 32'h0, 4'hF, 1'b0, 32'h0002_0001);
        // Aliases through address bits 1..0 and 7..6
        add_entry("rd_alias_lo", 1'b0, 8'h03, 32'h0, 4'hF, 1'b0, 32'hA188_C366);
        add_entry("rd_alias_hi", 1'b0, 8'hC4, 32'h0, 4'hF, 1'b0, 32'h0000_0003);
        add_entry("wr_alias", 1'b1, 8'h42, 32'h0BAD_F00D, 4'hF, 1'b0, 32'h0);
        add_entry("rd_alias_both", 1'b0, 8'h81, 32'h0, 4'hF, 1'b0, 32'h0BAD_F00D);
        add_entry("rd_alias_idx15", 1'b0, 8'h7F, 32'h0, 4'hF, 1'b0, 32'h0);
        add_entry("rd_alias_sdr2", 1'b0, 8'hD5, 32'h0, 4'hF, 1'b0, 32'hF234_5678);
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    task automatic reset_image();
        foreach (img[i]) img[i] = 32'h0;
        img[`GLBL_CFG_IDX_SCRATCH0] = `GLBL_CFG_RST_SCRATCH;
        img[`GLBL_CFG_IDX_HARTID]   = `GLBL_CFG_RST_HARTID;
        img[`GLBL_CFG_IDX_SCRATCH2] = `GLBL_CFG_RST_SCRATCH;
        img[`GLBL_CFG_IDX_IRQ]      = `GLBL_CFG_RST_IRQ;
        img[`GLBL_CFG_IDX_SDR1]     = `GLBL_CFG_RST_SDR1;
        img[`GLBL_CFG_IDX_SDR2]     = `GLBL_CFG_RST_SDR2;
        img[`GLBL_CFG_IDX_CHIP_TAG] = `GLBL_CFG_RST_CHIP_TAG;
        img[`GLBL_CFG_IDX_REL_DATE] = `GLBL_CFG_RST_REL_DATE;
        img[`GLBL_CFG_IDX_REVISION] = `GLBL_CFG_RST_REVISION;
    endtask

    task automatic model_write(glbl_cfg_pkg::reg_index_t idx, glbl_cfg_pkg::reg_word_t wdata,
                               glbl_cfg_pkg::byte_en_t be);
        glbl_cfg_pkg::reg_word_t merged;
        merged = img[idx];
        // Lane by lane merge
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        // Unstored bits
        if (idx == `GLBL_CFG_IDX_IRQ) begin
            merged = merged & 32'h000F_FFFF;
        end else if (idx == `GLBL_CFG_IDX_SDR1) begin
            merged = merged & 32'h3FFF_FFFF;
        end
        // Words 9 to 15 hold nothing
        if (idx <= `GLBL_CFG_IDX_REVISION) begin
            img[idx] = merged;
        end
    endtask

    function automatic glbl_cfg_pkg::irq_cfg_t expected_irq();
        glbl_cfg_pkg::irq_cfg_t e;
        glbl_cfg_pkg::reg_word_t w;
        w           = img[`GLBL_CFG_IDX_IRQ];
        e.irq_lines = w[15:0];
        e.soft_irq  = w[16];
        e.user_irq  = w[19:17];
        return e;
    endfunction

    // Field slices of words 4 and 5, low field first
    function automatic glbl_cfg_pkg::sdr_cfg_t expected_sdr();
        glbl_cfg_pkg::sdr_cfg_t e;
        glbl_cfg_pkg::reg_word_t w4;
        glbl_cfg_pkg::reg_word_t w5;
        w4          = img[`GLBL_CFG_IDX_SDR1];
        w5          = img[`GLBL_CFG_IDX_SDR2];
        e.width     = w4[1:0];
        e.colbits   = w4[3:2];
        e.tras      = w4[7:4];
        e.trp       = w4[11:8];
        e.trcd      = w4[15:12];
        e.trcar     = w4[19:16];
        e.twr       = w4[23:20];
        e.req_depth = w4[25:24];
        e.cas       = w4[28:26];
        e.en        = w4[29];
        e.rfmax     = w5[2:0];
        e.mode_reg  = w5[15:3];
        e.rfsh      = w5[27:16];
        return e;
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(string name, glbl_cfg_pkg::reg_word_t exp_v,
                              glbl_cfg_pkg::reg_word_t act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Result: FAILED");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_irq(string name, glbl_cfg_pkg::irq_cfg_t exp_v,
                             glbl_cfg_pkg::irq_cfg_t act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Result: FAILED");
            $fatal(1, "irq compare failed");
        end
    endtask

    task automatic check_sdr(string name, glbl_cfg_pkg::sdr_cfg_t exp_v,
                             glbl_cfg_pkg::sdr_cfg_t act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Result: FAILED");
            $fatal(1, "sdr compare failed");
        end
    endtask

    task automatic check_ack(string name, logic exp_v, logic act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp_v, act_v);
            $display("Result: FAILED");
            $fatal(1, "ack compare failed");
        end
    endtask

    task automatic check_latency(string name, int exp_v, int act_v);
        if (act_v != exp_v) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp_v, act_v);
            $display("Result: FAILED");
            $fatal(1, "latency compare failed");
        end
    endtask

    // ------------------------------------------------------------------
    // One bus access, entered and left just after a rising edge
    // ------------------------------------------------------------------
    task automatic run_access(int n);
        glbl_cfg_pkg::reg_addr_t  addr;
        glbl_cfg_pkg::reg_index_t idx;
        int                       wait_cycles;
        addr        = tc_addr[n];
        idx         = addr[5:2];
        wait_cycles = 0;
        reg_cs        <= 1'b1;
        reg_wr        <= tc_wr[n];
        reg_addr      <= addr;
        reg_wdata     <= tc_wdata[n];
        reg_be        <= tc_be[n];
        sdr_init_done <= tc_init[n];
        // Sample on the falling edge, away from the DUT updates
        @(negedge mclk);
        while (reg_ack !== 1'b1) begin
            wait_cycles++;
            @(negedge mclk);
        end
        check_latency({tc_name[n], " ack latency"}, ACK_LATENCY, wait_cycles);
        if (tc_wr[n]) begin
            model_write(idx, tc_wdata[n], tc_be[n]);
        end else begin
            check_word(tc_name[n], tc_exp[n], reg_rdata);
        end
        check_word({tc_name[n], " fuse_mhartid"}, img[`GLBL_CFG_IDX_HARTID], fuse_mhartid);
        check_irq({tc_name[n], " irq_cfg"}, expected_irq(), irq_cfg);
        check_sdr({tc_name[n], " sdr_cfg"}, expected_sdr(), sdr_cfg);
        // Chip select low for two cycles
        @(posedge mclk);
        reg_cs <= 1'b0;
        reg_wr <= 1'b0;
        // Single pulse, nothing more while the held select drains
        repeat (2) begin
            @(negedge mclk);
            check_ack({tc_name[n], " reg_ack after pulse"}, 1'b0, reg_ack);
        end
        @(posedge mclk);
    endtask

    // ------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (RESET_CYCLES + tc_name.size() * CYCLES_PER_ACCESS) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout waiting for reg_ack");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    // Main sequence
    initial begin
        reset_n       = 1'b0;
        reg_cs        = 1'b0;
        reg_wr        = 1'b0;
        reg_addr      = 8'h00;
        reg_wdata     = 32'h0;
        reg_be        = 4'h0;
        sdr_init_done = 1'b0;
        build_table();
        reset_image();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge mclk);
        reset_n <= 1'b1;
        @(posedge mclk);
        for (int n = 0; n < tc_name.size(); n++) begin
            run_access(n);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* hdl/glbl_cfg_top.sv */
`timescale 1ns/1ps

module glbl_cfg_top (
    input  logic                    mclk,
    input  logic                    reset_n,

    // Register bus
    input  logic                    reg_cs,
    input  logic                    reg_wr,
    input  glbl_cfg_pkg::reg_addr_t reg_addr,
    input  glbl_cfg_pkg::reg_word_t reg_wdata,
    input  glbl_cfg_pkg::byte_en_t  reg_be,
    output glbl_cfg_pkg::reg_word_t reg_rdata,
    output logic                    reg_ack,

    // RISC-V core configuration
    output glbl_cfg_pkg::reg_word_t fuse_mhartid,
    output glbl_cfg_pkg::irq_cfg_t  irq_cfg,

    // SDRAM controller configuration and status
    input  logic                    sdr_init_done,
    output glbl_cfg_pkg::sdr_cfg_t  sdr_cfg
);

    // Request fan-out
    glbl_cfg_pkg::reg_wr_req_t wr_req;

    // Per-bank read words
    glbl_cfg_pkg::reg_word_t rd_word_riscv;
    glbl_cfg_pkg::reg_word_t rd_word_sdr;
    glbl_cfg_pkg::reg_word_t rd_word_id;

    // ------------------------------------------------------------------
    // Bus front end
    // ------------------------------------------------------------------
    reg_bus_front u_front (
        .mclk          (mclk),
        .reset_n       (reset_n),
        .reg_cs        (reg_cs),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_be        (reg_be),
        .rd_word_riscv (rd_word_riscv),
        .rd_word_sdr   (rd_word_sdr),
        .rd_word_id    (rd_word_id),
        .wr_req        (wr_req),
        .reg_rdata     (reg_rdata),
        .reg_ack       (reg_ack)
    );

    // ------------------------------------------------------------------
    // Register banks
    // ------------------------------------------------------------------
    // Words 1 and 3
    riscv_cfg_bank u_riscv (
        .mclk         (mclk),
        .reset_n      (reset_n),
        .wr_req       (wr_req),
        .rd_word      (rd_word_riscv),
        .fuse_mhartid (fuse_mhartid),
        .irq_cfg      (irq_cfg)
    );

    // Words 4 and 5
    sdram_cfg_bank u_sdram (
        .mclk          (mclk),
        .reset_n       (reset_n),
        .wr_req        (wr_req),
        .sdr_init_done (sdr_init_done),
        .rd_word       (rd_word_sdr),
        .sdr_cfg       (sdr_cfg)
    );

    // Words 0, 2 and 6 to 8
    id_reg_bank u_id (
        .mclk    (mclk),
        .reset_n (reset_n),
        .wr_req  (wr_req),
        .rd_word (rd_word_id)
    );

endmodule

/* hdl/id_reg_bank.sv */
`timescale 1ns/1ps

`include "glbl_cfg_params.svh"

module id_reg_bank (
    input  logic                      mclk,
    input  logic                      reset_n,
    input  glbl_cfg_pkg::reg_wr_req_t wr_req,
    output glbl_cfg_pkg::reg_word_t   rd_word
);

    // Scratch words then identity words
    localparam int NREG = 5;

    localparam glbl_cfg_pkg::reg_index_t REG_IDX [NREG] = '{
        `GLBL_CFG_IDX_SCRATCH0,
        `GLBL_CFG_IDX_SCRATCH2,
        `GLBL_CFG_IDX_CHIP_TAG,
        `GLBL_CFG_IDX_REL_DATE,
        `GLBL_CFG_IDX_REVISION
    };

    localparam glbl_cfg_pkg::reg_word_t REG_RST [NREG] = '{
        `GLBL_CFG_RST_SCRATCH,
        `GLBL_CFG_RST_SCRATCH,
        `GLBL_CFG_RST_CHIP_TAG,
        `GLBL_CFG_RST_REL_DATE,
        `GLBL_CFG_RST_REVISION
    };

    glbl_cfg_pkg::reg_word_t reg_q [NREG];

    // ------------------------------------------------------------------
    // One read/write word per entry
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NREG; i++) begin : g_reg
        byte_en_reg #(
            .WIDTH     (`GLBL_CFG_DW),
            .RESET_VAL (REG_RST[i])
        ) u_reg (
            .mclk    (mclk),
            .reset_n (reset_n),
            .wr_en   (wr_req.wr_en && (wr_req.index == REG_IDX[i])),
            .be      (wr_req.be),
            .wdata   (wr_req.wdata),
            .q       (reg_q[i])
        );
    end

    // Read select, indices 9 to 15 fall through as zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < NREG; i++) begin
            if (wr_req.index == REG_IDX[i]) begin
                rd_word = reg_q[i];
            end
        end
    end

endmodule

/* hdl/sdram_cfg_bank.sv */
`timescale 1ns/1ps

`include "glbl_cfg_params.svh"

module sdram_cfg_bank (
    input  logic                      mclk,
    input  logic                      reset_n,
    input  glbl_cfg_pkg::reg_wr_req_t wr_req,
    // Status from the SDRAM controller
    input  logic                      sdr_init_done,
    output glbl_cfg_pkg::reg_word_t   rd_word,
    output glbl_cfg_pkg::sdr_cfg_t    sdr_cfg
);

    // Stored words, viewed through their layouts
    glbl_cfg_pkg::sdr_ctrl1_t ctrl1_q;
    glbl_cfg_pkg::sdr_ctrl2_t ctrl2_q;

    // Word 4 as seen on a read
    glbl_cfg_pkg::sdr_ctrl1_t ctrl1_rd;

    // ------------------------------------------------------------------
    // Word 4, SDRAM control 1
    // ------------------------------------------------------------------
    // Top two bits never stored
    byte_en_reg #(
        .WIDTH     (`GLBL_CFG_DW),
        .RESET_VAL (`GLBL_CFG_RST_SDR1)
    ) u_ctrl1 (
        .mclk    (mclk),
        .reset_n (reset_n),
        .wr_en   (wr_req.wr_en && (wr_req.index == `GLBL_CFG_IDX_SDR1)),
        .be      (wr_req.be),
        .wdata   ({2'b00, wr_req.wdata[29:0]}),
        .q       (ctrl1_q)
    );

    // ------------------------------------------------------------------
    // Word 5, SDRAM control 2
    // ------------------------------------------------------------------
    // Spare nibble kept and read back
    byte_en_reg #(
        .WIDTH     (`GLBL_CFG_DW),
        .RESET_VAL (`GLBL_CFG_RST_SDR2)
    ) u_ctrl2 (
        .mclk    (mclk),
        .reset_n (reset_n),
        .wr_en   (wr_req.wr_en && (wr_req.index == `GLBL_CFG_IDX_SDR2)),
        .be      (wr_req.be),
        .wdata   (wr_req.wdata),
        .q       (ctrl2_q)
    );

    // Live status in bit 30, bit 31 zero
    always_comb begin
        ctrl1_rd           = ctrl1_q;
        ctrl1_rd.init_done = sdr_init_done;
        ctrl1_rd.spare     = 1'b0;
    end

    // Controller bundle
    always_comb begin
        sdr_cfg.en        = ctrl1_q.en;
        sdr_cfg.cas       = ctrl1_q.cas;
        sdr_cfg.req_depth = ctrl1_q.req_depth;
        sdr_cfg.twr       = ctrl1_q.twr;
        sdr_cfg.trcar     = ctrl1_q.trcar;
        sdr_cfg.trcd      = ctrl1_q.trcd;
        sdr_cfg.trp       = ctrl1_q.trp;
        sdr_cfg.tras      = ctrl1_q.tras;
        sdr_cfg.colbits   = ctrl1_q.colbits;
        sdr_cfg.width     = ctrl1_q.width;
        sdr_cfg.rfsh      = ctrl2_q.rfsh;
        sdr_cfg.mode_reg  = ctrl2_q.mode_reg;
        sdr_cfg.rfmax     = ctrl2_q.rfmax;
    end

    // Read mux for words 4 and 5
    always_comb begin
        case (wr_req.index)
            `GLBL_CFG_IDX_SDR1: rd_word = ctrl1_rd;
            `GLBL_CFG_IDX_SDR2: rd_word = ctrl2_q;
            default:            rd_word = '0;
        endcase
    end

endmodule

/* hdl/riscv_cfg_bank.sv */
`timescale 1ns/1ps

`include "glbl_cfg_params.svh"

module riscv_cfg_bank (
    input  logic                      mclk,
    input  logic                      reset_n,
    input  glbl_cfg_pkg::reg_wr_req_t wr_req,
    output glbl_cfg_pkg::reg_word_t   rd_word,
    output glbl_cfg_pkg::reg_word_t   fuse_mhartid,
    output glbl_cfg_pkg::irq_cfg_t    irq_cfg
);

    localparam glbl_cfg_pkg::reg_word_t IRQ_RST = `GLBL_CFG_RST_IRQ;

    // Stored words
    glbl_cfg_pkg::reg_word_t hartid_q;
    logic [23:0]             irq_q;

    // Word 1, hart ID fuse
    byte_en_reg #(
        .WIDTH     (`GLBL_CFG_DW),
        .RESET_VAL (`GLBL_CFG_RST_HARTID)
    ) u_hartid (
        .mclk    (mclk),
        .reset_n (reset_n),
        .wr_en   (wr_req.wr_en && (wr_req.index == `GLBL_CFG_IDX_HARTID)),
        .be      (wr_req.be),
        .wdata   (wr_req.wdata),
        .q       (hartid_q)
    );

    // Word 3, interrupt control
    // Bits 23..20 forced to zero on the way in
    byte_en_reg #(
        .WIDTH     (24),
        .RESET_VAL (IRQ_RST[23:0])
    ) u_irq (
        .mclk    (mclk),
        .reset_n (reset_n),
        .wr_en   (wr_req.wr_en && (wr_req.index == `GLBL_CFG_IDX_IRQ)),
        .be      (wr_req.be),
        .wdata   ({4'h0, wr_req.wdata[19:0]}),
        .q       (irq_q)
    );

    assign fuse_mhartid = hartid_q;
    assign irq_cfg      = glbl_cfg_pkg::irq_cfg_t'(irq_q[19:0]);

    // Read mux for words 1 and 3
    always_comb begin
        case (wr_req.index)
            `GLBL_CFG_IDX_HARTID: rd_word = hartid_q;
            `GLBL_CFG_IDX_IRQ:    rd_word = {8'h00, irq_q};
            default:              rd_word = '0;
        endcase
    end

endmodule

/* hdl/reg_bus_front.sv */
`timescale 1ns/1ps

module reg_bus_front (
    input  logic                      mclk,
    input  logic                      reset_n,

    // Register bus from the master
    input  logic                      reg_cs,
    input  logic                      reg_wr,
    input  glbl_cfg_pkg::reg_addr_t   reg_addr,
    input  glbl_cfg_pkg::reg_word_t   reg_wdata,
    input  glbl_cfg_pkg::byte_en_t    reg_be,

    // Read words from the banks, zero when not addressed
    input  glbl_cfg_pkg::reg_word_t   rd_word_riscv,
    input  glbl_cfg_pkg::reg_word_t   rd_word_sdr,
    input  glbl_cfg_pkg::reg_word_t   rd_word_id,

    // Registered request to the banks
    output glbl_cfg_pkg::reg_wr_req_t wr_req,

    // Bus response
    output glbl_cfg_pkg::reg_word_t   reg_rdata,
    output logic                      reg_ack
);

    // Delayed chip select, two stages
    logic cs_d1;
    logic cs_d2;

    // Combined read word
    glbl_cfg_pkg::reg_word_t rd_or;

    // Access ready to be acknowledged
    logic ack_go;

    // ------------------------------------------------------------------
    // Request capture on the first edge with reg_cs high
    // ------------------------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            wr_req <= '0;
            cs_d1  <= 1'b0;
            cs_d2  <= 1'b0;
        end else begin
            wr_req.wr_en <= reg_cs & reg_wr;
            wr_req.rd_en <= reg_cs & ~reg_wr;
            // Word index only, bits 7..6 and 1..0 dropped
            wr_req.index <= reg_addr[5:2];
            wr_req.wdata <= reg_wdata;
            wr_req.be    <= reg_be;
            cs_d1        <= reg_cs;
            cs_d2        <= cs_d1;
        end
    end

    // Banks decode their own words, so a plain OR is enough
    assign rd_or = rd_word_riscv | rd_word_sdr | rd_word_id;

    // Held chip select shows up in cs_d2 and blocks a second pulse
    assign ack_go = (wr_req.wr_en | wr_req.rd_en) & ~reg_ack & ~cs_d2;

    // ------------------------------------------------------------------
    // Acknowledge and read data, one edge after capture
    // ------------------------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            reg_ack   <= 1'b0;
            reg_rdata <= '0;
        end else begin
            reg_ack <= ack_go;
            // Read data held until the next read
            if (ack_go && wr_req.rd_en) begin
                reg_rdata <= rd_or;
            end
        end
    end

endmodule

/* hdl/byte_en_reg.sv */
`timescale 1ns/1ps

module byte_en_reg #(
    // Multiple of 8, at most 32
    parameter int               WIDTH     = 32,
    parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
    input  logic                   mclk,
    input  logic                   reset_n,
    input  logic                   wr_en,
    input  glbl_cfg_pkg::byte_en_t be,
    input  logic [WIDTH-1:0]       wdata,
    output logic [WIDTH-1:0]       q
);

    // Number of byte lanes actually stored
    localparam int LANES = WIDTH / 8;

    // ------------------------------------------------------------------
    // Lane-wise update
    // ------------------------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            q <= RESET_VAL;
        end else if (wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                // Unselected lanes hold
                if (be[i]) begin
                    q[i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

/* hdl/glbl_cfg_pkg.sv */
`include "glbl_cfg_params.svh"

package glbl_cfg_pkg;

    // Plain vectors with a meaning
    typedef logic [`GLBL_CFG_DW-1:0] reg_word_t;
    typedef logic [7:0]              reg_addr_t;
    typedef logic [3:0]              reg_index_t;
    typedef logic [3:0]              byte_en_t;

    // Registered bus request, fanned out to every bank
    typedef struct packed {
        logic       wr_en;
        logic       rd_en;
        reg_index_t index;
        reg_word_t  wdata;
        byte_en_t   be;
    } reg_wr_req_t;

    // Interrupt control outputs, word 3 bits 19..0
    typedef struct packed {
        logic [2:0]  user_irq;
        logic        soft_irq;
        logic [15:0] irq_lines;
    } irq_cfg_t;

    // Word 4 layout, MSB first
    typedef struct packed {
        logic       spare;
        logic       init_done;
        logic       en;
        logic [2:0] cas;
        logic [1:0] req_depth;
        logic [3:0] twr;
        logic [3:0] trcar;
        logic [3:0] trcd;
        logic [3:0] trp;
        logic [3:0] tras;
        logic [1:0] colbits;
        // 0 is 32-bit, 1 is 16-bit, 2 or 3 is 8-bit
        logic [1:0] width;
    } sdr_ctrl1_t;

    // Word 5 layout, MSB first
    typedef struct packed {
        logic [3:0]  spare;
        logic [11:0] rfsh;
        logic [12:0] mode_reg;
        logic [2:0]  rfmax;
    } sdr_ctrl2_t;

    // Bundle for the SDRAM controller, word 4 fields above word 5 fields
    typedef struct packed {
        logic        en;
        logic [2:0]  cas;
        logic [1:0]  req_depth;
        logic [3:0]  twr;
        logic [3:0]  trcar;
        logic [3:0]  trcd;
        logic [3:0]  trp;
        logic [3:0]  tras;
        logic [1:0]  colbits;
        logic [1:0]  width;
        logic [11:0] rfsh;
        logic [12:0] mode_reg;
        logic [2:0]  rfmax;
    } sdr_cfg_t;

endpackage

/* hdl/glbl_cfg_params.svh */
`ifndef GLBL_CFG_PARAMS_SVH
`define GLBL_CFG_PARAMS_SVH

// ----------------------------------------------------------------------
// Register bus data width
// ----------------------------------------------------------------------
`define GLBL_CFG_DW 32

// ----------------------------------------------------------------------
// Word indices, taken from byte address bits 5..2
// ----------------------------------------------------------------------
`define GLBL_CFG_IDX_SCRATCH0  4'd0
`define GLBL_CFG_IDX_HARTID    4'd1
`define GLBL_CFG_IDX_SCRATCH2  4'd2
`define GLBL_CFG_IDX_IRQ       4'd3
`define GLBL_CFG_IDX_SDR1      4'd4
`define GLBL_CFG_IDX_SDR2      4'd5
`define GLBL_CFG_IDX_CHIP_TAG  4'd6
`define GLBL_CFG_IDX_REL_DATE  4'd7
`define GLBL_CFG_IDX_REVISION  4'd8

// ----------------------------------------------------------------------
// Reset values
// ----------------------------------------------------------------------
`define GLBL_CFG_RST_SCRATCH   32'hAABB_CCDD
`define GLBL_CFG_RST_HARTID    32'hA55A_A55A
`define GLBL_CFG_RST_IRQ       32'h0000_0000
`define GLBL_CFG_RST_SDR1      32'h0000_0000
// rfsh 0x100, mode reg 0x033, rfmax 6
`define GLBL_CFG_RST_SDR2      32'h0100_019E
// ASCII tag of the chip
`define GLBL_CFG_RST_CHIP_TAG  32'h5946_4956
`define GLBL_CFG_RST_REL_DATE  32'h2212_2021
// Revision 1.8
`define GLBL_CFG_RST_REVISION  32'h0001_8000

`endif
